// File: cpu_top.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/dual_port_ram.sv
hdl/regfile.sv
hdl/alu.sv
hdl/program_counter.sv
hdl/control_decoder.sv
hdl/cpu_top.sv
tb/cpu_top_sva.sv
tb/cpu_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cpu_top testbench with Verilator, log goes to sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cpu_top_tb -Mdir obj_dir -o cpu_top_sim -f cpu_top.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/cpu_top_sim 2>&1 | tee sim.log
status=${PIPESTATUS[0]}
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

grep -q "Result: FAILED" sim.log
found=$?
if [ $found -eq 0 ]; then
	echo "simulation reported failure, see sim.log"
	exit 1
elif [ $found -ne 1 ]; then
	echo "could not search sim.log"
	exit 1
fi

echo "simulation finished without failures"
exit 0

// File: tb/cpu_stimulus.txt
# records: T name | W addr word... | S | C addr expected... | B expected_bad_op
# addresses and words in hex; W and C cover consecutive addresses from addr
T arith_logic
W 00 715A 72C3 7F80 5310 0320 B3F0 6F01 5310 1320 B3F0 6F01 5310 2320 B3F0 6F01 5310
W 10 3320 B3F0 6F01 5310 4320 B3F0 6F01 7404 5310 8340 B3F0 6F01 5310 637F B3F0 6F01
W 20 5320 B3F0 E000
S
B 0
C 80 001D 0097 0042 FFDB FF99 05A0 00D9 FFC3
# cmp 5,5 then cmp 3,5; untaken branches store the marker, taken ones keep 7A7A
T flags_branch
W 00 7105 7205 7733 78A0 79A1 7AA2 7BA3 7CA4 7DA5 7EA6 9120 C001 B780 C101 B790 C201
W 10 B7A0 C301 B7B0 C401 B7C0 C501 B7D0 C601 B7E0 6810 6910 6A10 6B10 6C10 6D10 6E10
W 20 7103 7744 9120 C001 B780 C101 B790 C201 B7A0 C301 B7B0 C401 B7C0 C501 B7D0 C601
W 30 B7E0 E000
W A0 7A7A 7A7A 7A7A 7A7A 7A7A 7A7A 7A7A
W B0 7A7A 7A7A 7A7A 7A7A 7A7A 7A7A 7A7A
S
B 0
C A0 7A7A 0033 7A7A 0033 0033 7A7A 7A7A
C B0 0044 7A7A 0044 7A7A 7A7A 0044 7A7A
T load_store_jump
W 00 71C0 72C1 7AD0 A410 A520 B4A0 0450 6A01 B4A0 6A01 7610 D060 B5A0 6A01 D660 B4A0
W 10 7755 6A01 B7A0 E000
W C0 1234 0F0F
W D0 EEEE EEEE EEEE EEEE EEEE
S
B 0
C D0 1234 2143 0F0F EEEE 0055
C C0 1234 0F0F
T ext_port
W E0 DEAD BEEF 0000 FFFF
C E0 DEAD BEEF 0000 FFFF
W 00 7133 7FF0 B1F0 E000
W F0 0000
S
B 0
C E0 DEAD BEEF 0000 FFFF
C F0 0033
T illegal_op
W 00 7166 7FF8 B1F0 F000 6F01 B1F0 E000
W F8 0000 0000
S
B 1
C F8 0066 0000
T bad_op_clear
W 00 E000
S
B 0

// File: tb/cpu_top_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top_tb;

	localparam int CLK_HALF = 2; // 4 ns period
	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_RECORD = 200;
	localparam int RUN_LIMIT = 300; // cycles from start to done
	localparam string STIM_FILE = "tb/cpu_stimulus.txt";

	logic clk;
	logic reset;
	logic start;
	logic ext_we;
	isa_pkg::ram_addr_t ext_addr;
	isa_pkg::word_t ext_wdata;
	isa_pkg::word_t ext_rdata;
	logic busy;
	logic done;
	logic bad_op;

	string fields[$]; // tokens of the current stimulus line
	int watchdog_cycles;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int test_errors;
	string test_name;

	cpu_top uut (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.ext_we    (ext_we),
		.ext_addr  (ext_addr),
		.ext_wdata (ext_wdata),
		.ext_rdata (ext_rdata),
		.busy      (busy),
		.done      (done),
		.bad_op    (bad_op)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	function automatic bit is_blank(byte c);
		return c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d;
	endfunction

	// whitespace tokenizer into fields
	function automatic void split_line(string s);
		int first;
		fields.delete();
		first = -1;
		for (int i = 0; i < s.len(); i++) begin
			if (is_blank(s[i])) begin
				if (first >= 0)
					fields.push_back(s.substr(first, i - 1));
				first = -1;
			end else if (first < 0) begin
				first = i; // token begins
			end
		end
		if (first >= 0)
			fields.push_back(s.substr(first, s.len() - 1));
	endfunction

	function automatic bit has_record();
		return fields.size() > 0 && fields[0].substr(0, 0) != "#"; // skips blank and comment lines
	endfunction

	function automatic isa_pkg::word_t field_hex(int idx);
		int v;
		v = fields[idx].atohex();
		return v[`CPU_DATA_W-1:0];
	endfunction

	function automatic isa_pkg::ram_addr_t field_addr(int idx);
		int v;
		v = fields[idx].atohex();
		return v[`CPU_RAM_AW-1:0];
	endfunction

	task automatic check_value(string name, isa_pkg::word_t actual, isa_pkg::word_t expected);
		checks++;
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%04h, expected 0x%04h", name, actual, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_failure(string what);
		$display("error: %s", what);
		errors++;
		test_errors++;
	endtask

	// port B writes one word per cycle from base upward
	task automatic write_words(isa_pkg::ram_addr_t base);
		isa_pkg::ram_addr_t a;
		a = base;
		for (int i = 2; i < fields.size(); i++) begin
			@(posedge clk);
			ext_we <= 1'b1;
			ext_addr <= a;
			ext_wdata <= field_hex(i);
			a = a + 1'b1;
		end
		@(posedge clk);
		ext_we <= 1'b0;
	endtask

	task automatic read_check(isa_pkg::ram_addr_t base);
		isa_pkg::ram_addr_t a;
		a = base;
		for (int i = 2; i < fields.size(); i++) begin
			@(posedge clk);
			ext_addr <= a;
			@(posedge clk); // registered read
			@(negedge clk);
			check_value($sformatf("ext_rdata[%02h]", a), ext_rdata, field_hex(i));
			a = a + 1'b1;
		end
	endtask

	task automatic run_program();
		logic seen;
		seen = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_value("busy", isa_pkg::word_t'(busy), isa_pkg::word_t'(1'b1)); // high after start
		@(posedge clk);
		start <= 1'b1; // lands while busy and is ignored
		@(posedge clk);
		start <= 1'b0;
		for (int n = 0; n < RUN_LIMIT && !seen; n++) begin
			@(negedge clk);
			seen = done;
		end
		if (!seen) begin
			report_failure($sformatf("no done pulse within %0d cycles of start", RUN_LIMIT));
		end else begin
			@(negedge clk); // one cycle past done
			check_value("busy", isa_pkg::word_t'(busy), '0);
		end
	endtask

	task automatic finish_test();
		if (test_name != "") begin
			tests_run++;
			if (test_errors == 0) begin
				$display("test %s: ok", test_name);
			end else begin
				tests_failed++;
				$display("test %s: failed with %0d errors", test_name, test_errors);
			end
		end
		test_errors = 0;
	endtask

	task automatic apply_record();
		if (fields[0] == "T") begin
			finish_test();
			test_name = fields[1];
		end else if (fields[0] == "W") begin
			write_words(field_addr(1));
		end else if (fields[0] == "S") begin
			run_program();
		end else if (fields[0] == "C") begin
			read_check(field_addr(1));
		end else if (fields[0] == "B") begin
			@(negedge clk);
			check_value("bad_op", isa_pkg::word_t'(bad_op), field_hex(1));
		end else begin
			report_failure($sformatf("unknown record type %s in stimulus file", fields[0]));
		end
	endtask

	initial begin
		int fd;
		int records;
		string line;
		reset = 1'b0;
		start = 1'b0;
		ext_we = 1'b0;
		ext_addr = '0;
		ext_wdata = '0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		test_errors = 0;
		test_name = "";
		watchdog_cycles = 0;
		records = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			report_failure($sformatf("cannot open stimulus file %s", STIM_FILE));
		end else begin
			// first pass only sizes the watchdog
			while ($fgets(line, fd) != 0) begin
				split_line(line);
				if (has_record())
					records++;
			end
			$fclose(fd);
			watchdog_cycles = RESET_CYCLES + records * CYCLES_PER_RECORD;
			repeat (RESET_CYCLES) @(posedge clk);
			reset <= 1'b1;
			fd = $fopen(STIM_FILE, "r");
			while ($fgets(line, fd) != 0) begin
				split_line(line);
				if (has_record())
					apply_record();
			end
			$fclose(fd);
			finish_test(); // last test in the file
		end
		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// watchdog
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: run exceeded %0d clock cycles, simulation stopped", watchdog_cycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: tb/cpu_top_sva.sv
`timescale 1ns/1ps

module cpu_top_sva (
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done
);

	// done is a one-cycle strobe
	done_one_cycle: assert property (@(posedge clk) disable iff (!reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// done only closes a run in progress
	done_in_run: assert property (@(posedge clk) disable iff (!reset) done |-> busy)
		else $error("done pulsed while busy was low");

	// no activity while reset is held
	quiet_in_reset: assert property (@(posedge clk) !reset |-> (!busy && !done))
		else $error("busy or done high during reset");

	// repeated start is ignored, busy may only drop after the done cycle
	start_ignored: assert property (@(posedge clk) disable iff (!reset)
		(start && busy && !done) |=> busy)
		else $error("start while busy made busy fall");

endmodule

bind cpu_top cpu_top_sva u_sva (
	.clk   (clk),
	.reset (reset),
	.start (start),
	.busy  (busy),
	.done  (done)
);

// File: hdl/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic ext_we,
	input  isa_pkg::ram_addr_t ext_addr,
	input  isa_pkg::word_t ext_wdata,
	output isa_pkg::word_t ext_rdata,
	output logic busy,
	output logic done,
	output logic bad_op
);

	// control strobes
	logic pc_clear;
	logic pc_en;
	logic pc_branch;
	logic pc_load;
	logic addr_sel;
	logic reg_we;
	logic mem_we;
	logic use_imm;
	ctrl_pkg::wb_src_e wb_src;

	// decoded fields
	isa_pkg::opcode_e op;
	isa_pkg::reg_idx_t rdest;
	isa_pkg::reg_idx_t rsrc;
	isa_pkg::word_t imm; // immediate, displacement or jump target
	isa_pkg::flags_t flags;
	isa_pkg::flags_t flags_next;

	isa_pkg::word_t pc;
	isa_pkg::word_t q_a;        // port A read, instruction or load data
	isa_pkg::ram_addr_t mem_addr_a;
	isa_pkg::word_t rdest_val;
	isa_pkg::word_t rsrc_val;
	isa_pkg::word_t alu_b;
	isa_pkg::word_t alu_result;
	isa_pkg::word_t wb_data;

	// port A address: pc for fetch, rsrc register for load/store
	assign mem_addr_a = addr_sel ? rsrc_val[`CPU_RAM_AW-1:0] : pc[`CPU_RAM_AW-1:0];
	assign alu_b = use_imm ? imm : rsrc_val;
	assign wb_data = (wb_src == ctrl_pkg::WB_RAM) ? q_a : alu_result;

	// port A core, port B external word port
	dual_port_ram u_ram (
		.clk    (clk),
		.data_a (rdest_val), // store data
		.data_b (ext_wdata),
		.addr_a (mem_addr_a),
		.addr_b (ext_addr),
		.we_a   (mem_we),
		.we_b   (ext_we),
		.q_a    (q_a),
		.q_b    (ext_rdata)
	);

	control_decoder u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.instr      (q_a),
		.rsrc_val   (rsrc_val),
		.flags_next (flags_next),
		.busy       (busy),
		.done       (done),
		.bad_op     (bad_op),
		.pc_clear   (pc_clear),
		.pc_en      (pc_en),
		.pc_branch  (pc_branch),
		.pc_load    (pc_load),
		.addr_sel   (addr_sel),
		.reg_we     (reg_we),
		.mem_we     (mem_we),
		.use_imm    (use_imm),
		.wb_src     (wb_src),
		.op         (op),
		.rdest      (rdest),
		.rsrc       (rsrc),
		.imm        (imm),
		.flags      (flags)
	);

	program_counter u_pc (
		.clk    (clk),
		.reset  (reset),
		.clear  (pc_clear),
		.en     (pc_en),
		.branch (pc_branch),
		.load   (pc_load),
		.disp   (imm),
		.target (imm), // decoder puts rsrc value here on JCOND
		.pc     (pc)
	);

	regfile u_regs (
		.clk     (clk),
		.reset   (reset),
		.we      (reg_we),
		.waddr   (rdest),
		.wdata   (wb_data),
		.raddr_a (rdest),
		.raddr_b (rsrc),
		.rdata_a (rdest_val),
		.rdata_b (rsrc_val)
	);

	alu u_alu (
		.a         (rdest_val),
		.b         (alu_b),
		.op        (op),
		.flags_in  (flags),
		.result    (alu_result),
		.flags_out (flags_next)
	);

endmodule

// File: hdl/control_decoder.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module control_decoder (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  isa_pkg::word_t instr,
	input  isa_pkg::word_t rsrc_val,
	input  isa_pkg::flags_t flags_next,
	output logic busy,
	output logic done,
	output logic bad_op,
	output logic pc_clear,
	output logic pc_en,
	output logic pc_branch,
	output logic pc_load,
	output logic addr_sel,
	output logic reg_we,
	output logic mem_we,
	output logic use_imm,
	output ctrl_pkg::wb_src_e wb_src,
	output isa_pkg::opcode_e op,
	output isa_pkg::reg_idx_t rdest,
	output isa_pkg::reg_idx_t rsrc,
	output isa_pkg::word_t imm,
	output isa_pkg::flags_t flags
);

	ctrl_pkg::seq_state_e state;
	ctrl_pkg::seq_state_e state_next;
	isa_pkg::word_t ir;
	isa_pkg::cond_e cond;
	logic cond_ok;
	logic accept;     // start taken
	logic stop_op;    // halt or illegal seen at decode
	logic illegal;
	logic sets_flags;
	logic is_mem;

	// instruction register, loaded as the fetched word arrives
	always_ff @(posedge clk) begin
		if (state == ctrl_pkg::DECODE)
			ir <= instr;
	end

	// field decode
	assign op = isa_pkg::opcode_e'(ir[15:12]);
	assign rdest = ir[11:8];
	assign rsrc = ir[7:4];
	assign cond = isa_pkg::cond_e'(ir[11:8]);
	// jump target rides the same bus as the displacement
	// pc was bumped at fetch, so disp 0 lands on the next instruction
	assign imm = (op == isa_pkg::OP_JCOND) ? rsrc_val
		: {{(`CPU_DATA_W-8){ir[7]}}, ir[7:0]};
	assign use_imm = (op == isa_pkg::OP_ADDI) || (op == isa_pkg::OP_MOVI);
	assign is_mem = (op == isa_pkg::OP_LOAD) || (op == isa_pkg::OP_STOR);

	// stop check looks at the raw word, ir is not loaded yet
	assign illegal = instr[15:12] > `CPU_HALT_OP; // only 4'hf
	assign stop_op = instr[15:12] >= `CPU_HALT_OP;

	// busy still high during the done cycle
	assign accept = start && !busy && (state == ctrl_pkg::IDLE);

	always_comb begin
		case (cond)
			isa_pkg::COND_EQ: cond_ok = flags[`CPU_FLAG_Z];
			isa_pkg::COND_NE: cond_ok = !flags[`CPU_FLAG_Z];
			isa_pkg::COND_CS: cond_ok = flags[`CPU_FLAG_C];
			isa_pkg::COND_CC: cond_ok = !flags[`CPU_FLAG_C];
			isa_pkg::COND_LT: cond_ok = flags[`CPU_FLAG_N] != flags[`CPU_FLAG_V];
			isa_pkg::COND_GE: cond_ok = flags[`CPU_FLAG_N] == flags[`CPU_FLAG_V];
			isa_pkg::COND_AL: cond_ok = 1'b1;
			default: cond_ok = 1'b0; // unused codes never branch
		endcase
	end

	always_comb begin
		case (op)
			isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
			isa_pkg::OP_XOR, isa_pkg::OP_ADDI, isa_pkg::OP_LSH,
			isa_pkg::OP_CMP: sets_flags = 1'b1;
			default: sets_flags = 1'b0;
		endcase
	end

	// sequencer next state
	always_comb begin
		state_next = state;
		case (state)
			ctrl_pkg::IDLE: if (accept) state_next = ctrl_pkg::FETCH;
			ctrl_pkg::FETCH: state_next = ctrl_pkg::DECODE;
			ctrl_pkg::DECODE: state_next = stop_op ? ctrl_pkg::IDLE : ctrl_pkg::EXECUTE;
			ctrl_pkg::EXECUTE: state_next = is_mem ? ctrl_pkg::MEMORY : ctrl_pkg::FETCH;
			ctrl_pkg::MEMORY: state_next = ctrl_pkg::FETCH;
			default: state_next = ctrl_pkg::IDLE;
		endcase
	end

	// per-state strobes
	always_comb begin
		pc_clear = 1'b0;
		pc_en = 1'b0;
		pc_branch = 1'b0;
		pc_load = 1'b0;
		addr_sel = 1'b0; // port A at pc
		reg_we = 1'b0;
		mem_we = 1'b0;
		wb_src = ctrl_pkg::WB_ALU;
		case (state)
			ctrl_pkg::IDLE: pc_clear = accept;
			ctrl_pkg::FETCH: pc_en = 1'b1;
			ctrl_pkg::EXECUTE: begin
				case (op)
					isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
					isa_pkg::OP_XOR, isa_pkg::OP_MOV, isa_pkg::OP_ADDI,
					isa_pkg::OP_MOVI, isa_pkg::OP_LSH: reg_we = 1'b1;
					isa_pkg::OP_BCOND: begin
						pc_en = cond_ok; // untaken costs the same 3 cycles
						pc_branch = 1'b1;
					end
					isa_pkg::OP_JCOND: begin
						pc_en = cond_ok;
						pc_load = 1'b1;
					end
					// address goes out a cycle early, registered read
					isa_pkg::OP_LOAD, isa_pkg::OP_STOR: addr_sel = 1'b1;
					default: ;
				endcase
			end
			ctrl_pkg::MEMORY: begin
				addr_sel = 1'b1; // rsrc register as address
				if (op == isa_pkg::OP_LOAD) begin
					reg_we = 1'b1;
					wb_src = ctrl_pkg::WB_RAM;
				end
				mem_we = (op == isa_pkg::OP_STOR);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= ctrl_pkg::IDLE;
			busy <= 1'b0;
			done <= 1'b0;
			bad_op <= 1'b0;
			flags <= '0;
		end else begin
			state <= state_next;
			done <= (state == ctrl_pkg::DECODE) && stop_op; // one-cycle pulse
			if (accept)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0; // drops after the done cycle
			if (accept)
				bad_op <= 1'b0;
			else if (state == ctrl_pkg::DECODE && illegal)
				bad_op <= 1'b1; // rises with done
			if (state == ctrl_pkg::EXECUTE && sets_flags)
				flags <= flags_next;
		end
	end

endmodule

// File: hdl/program_counter.sv
`timescale 1ns/1ps

module program_counter (
	input  logic clk,
	input  logic reset,
	input  logic clear,
	input  logic en,
	input  logic branch,
	input  logic load,
	input  isa_pkg::word_t disp,
	input  isa_pkg::word_t target,
	output isa_pkg::word_t pc
);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= '0;
		end else if (clear) begin
			pc <= '0; // run starts at address 0
		end else if (en) begin
			if (load)
				pc <= target;      // register jump
			else if (branch)
				pc <= pc + disp;   // disp already sign-extended
			else
				pc <= pc + 1'b1;   // fetch step
		end
	end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu (
	input  isa_pkg::word_t a,
	input  isa_pkg::word_t b,
	input  isa_pkg::opcode_e op,
	input  isa_pkg::flags_t flags_in,
	output isa_pkg::word_t result,
	output isa_pkg::flags_t flags_out
);

	localparam int W = `CPU_DATA_W;
	localparam int SHW = $clog2(W); // shift amount bits

	logic [W:0] sum;  // msb is carry out
	logic [W:0] diff; // msb set means no borrow
	logic add_v;
	logic sub_v;
	logic c;
	logic v;
	logic set_all; // c z n v
	logic set_zn;  // logic ops, shift

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1; // a + ~b + 1

	// signed overflow
	assign add_v = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
	assign sub_v = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

	always_comb begin
		result = a;
		c = 1'b0;
		v = 1'b0;
		set_all = 1'b0;
		set_zn = 1'b0;
		case (op)
			isa_pkg::OP_ADD, isa_pkg::OP_ADDI: begin
				result = sum[W-1:0];
				c = sum[W];
				v = add_v;
				set_all = 1'b1;
			end
			isa_pkg::OP_SUB, isa_pkg::OP_CMP: begin // cmp result is never written
				result = diff[W-1:0];
				c = diff[W];
				v = sub_v;
				set_all = 1'b1;
			end
			isa_pkg::OP_AND: begin
				result = a & b;
				set_zn = 1'b1;
			end
			isa_pkg::OP_OR: begin
				result = a | b;
				set_zn = 1'b1;
			end
			isa_pkg::OP_XOR: begin
				result = a ^ b;
				set_zn = 1'b1;
			end
			isa_pkg::OP_LSH: begin
				result = a << b[SHW-1:0]; // low 4 bits of rsrc
				set_zn = 1'b1;
			end
			isa_pkg::OP_MOV, isa_pkg::OP_MOVI: result = b;
			default: result = a; // load, store, branches, halt
		endcase
	end

	// flag merge, untouched bits pass through
	always_comb begin
		flags_out = flags_in;
		if (set_all || set_zn) begin
			flags_out[`CPU_FLAG_Z] = (result == '0);
			flags_out[`CPU_FLAG_N] = result[W-1];
		end
		if (set_all) begin
			flags_out[`CPU_FLAG_C] = c;
			flags_out[`CPU_FLAG_V] = v;
		end
	end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regfile (
	input  logic clk,
	input  logic reset,
	input  logic we,
	input  isa_pkg::reg_idx_t waddr,
	input  isa_pkg::word_t wdata,
	input  isa_pkg::reg_idx_t raddr_a,
	input  isa_pkg::reg_idx_t raddr_b,
	output isa_pkg::word_t rdata_a,
	output isa_pkg::word_t rdata_b
);

	isa_pkg::word_t regs [`CPU_NREGS];

	// write port, all registers start at zero
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// async reads
	// a = rdest side (alu a, store data)
	assign rdata_a = regs[raddr_a];
	// b = rsrc side (alu b, address, jump target)
	assign rdata_b = regs[raddr_b];

endmodule

// File: hdl/dual_port_ram.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module dual_port_ram (
	input  logic clk,
	input  isa_pkg::word_t data_a,
	input  isa_pkg::word_t data_b,
	input  isa_pkg::ram_addr_t addr_a,
	input  isa_pkg::ram_addr_t addr_b,
	input  logic we_a,
	input  logic we_b,
	output isa_pkg::word_t q_a,
	output isa_pkg::word_t q_b
);

	localparam int DEPTH = 1 << `CPU_RAM_AW;

	isa_pkg::word_t mem [DEPTH];

	// one process for both ports so the array has a single driver
	always_ff @(posedge clk) begin
		if (we_a)
			mem[addr_a] <= data_a;
		if (we_b)
			mem[addr_b] <= data_b; // port b wins a same-address collision
		q_a <= mem[addr_a]; // old word on a write
		q_b <= mem[addr_b];
	end

endmodule

// File: hdl/ctrl_pkg.sv
package ctrl_pkg;

	// multicycle sequencer
	typedef enum logic [2:0] {
		IDLE,    // waiting for start
		FETCH,   // port A at pc, pc increments
		DECODE,  // instruction word arrives, ir latched
		EXECUTE, // alu, branch, write-back
		MEMORY   // load and store only
	} seq_state_e;

	// register file write data
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_RAM = 1'b1 // port A read data
	} wb_src_e;

endpackage

// File: hdl/isa_pkg.sv
`include "cpu_consts.svh"

package isa_pkg;

	typedef logic [`CPU_DATA_W-1:0] word_t; // data or instruction word
	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;
	typedef logic [`CPU_RAM_AW-1:0] ram_addr_t;
	typedef logic [3:0] flags_t; // c z n v, see CPU_FLAG_*

	// opcode field, instr[15:12]; 4'hf is left unnamed and traps as illegal
	typedef enum logic [3:0] {
		OP_ADD   = 4'h0,
		OP_SUB   = 4'h1,
		OP_AND   = 4'h2,
		OP_OR    = 4'h3,
		OP_XOR   = 4'h4,
		OP_MOV   = 4'h5,
		OP_ADDI  = 4'h6, // sign-extended imm8
		OP_MOVI  = 4'h7,
		OP_LSH   = 4'h8,
		OP_CMP   = 4'h9, // flags only
		OP_LOAD  = 4'ha,
		OP_STOR  = 4'hb,
		OP_BCOND = 4'hc, // pc relative
		OP_JCOND = 4'hd, // pc from rsrc
		OP_HALT  = `CPU_HALT_OP
	} opcode_e;

	// branch condition, rides in the rdest field
	typedef enum logic [3:0] {
		COND_EQ = 4'h0,
		COND_NE = 4'h1,
		COND_CS = 4'h2,
		COND_CC = 4'h3,
		COND_LT = 4'h4,
		COND_GE = 4'h5,
		COND_AL = 4'h6
	} cond_e;

endpackage

// File: hdl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and instruction word width
`define CPU_DATA_W 16
// port A and port B address width, 256 words
`define CPU_RAM_AW 8
`define CPU_NREGS 16
// highest legal opcode; anything above is illegal
`define CPU_HALT_OP 4'hE

// bit positions in the flag vector
`define CPU_FLAG_C 3
`define CPU_FLAG_Z 2
`define CPU_FLAG_N 1
`define CPU_FLAG_V 0

`endif
